/* project.f */
+incdir+logic
+incdir+verif
logic/lsu_pkg.sv
logic/lsu_pipe.sv
logic/dcache_store.sv
logic/mem_manager.sv
logic/lsu_top.sv
verif/lsu_tb.sv

/* verif/lsu_tb_table.svh */
`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

// columns: name, write, size, address, write data, stall cycles, expected load data
task automatic build_table();
  // cold miss, then a write-allocate fill and hits on it
  add_entry("cold_miss_word", 1'b0, SIZE_WORD, 32'h00000100, 32'h00000000, 0, 32'h00000000);
  add_entry("fill_store", 1'b1, SIZE_WORD, 32'h00000044, 32'hdeadbeef, 0, 32'h00000000);
  add_entry("load_behind_st", 1'b0, SIZE_WORD, 32'h00000044, 32'h00000000, 0, 32'hdeadbeef);
  add_entry("hit_word", 1'b0, SIZE_WORD, 32'h00000044, 32'h00000000, 0, 32'hdeadbeef);
  // partial stores touch only their lanes
  add_entry("byte_store_b2", 1'b1, SIZE_BYTE, 32'h00000046, 32'h000000a5, 0, 32'h00000000);
  add_entry("byte_load_b2", 1'b0, SIZE_BYTE, 32'h00000046, 32'h00000000, 0, 32'h000000a5);
  add_entry("half_load_hi", 1'b0, SIZE_HALF, 32'h00000046, 32'h00000000, 0, 32'h0000dea5);
  add_entry("half_load_lo", 1'b0, SIZE_HALF, 32'h00000044, 32'h00000000, 0, 32'h0000beef);
  add_entry("half_store_lo", 1'b1, SIZE_HALF, 32'h00000044, 32'h00001234, 0, 32'h00000000);
  add_entry("word_after_half", 1'b0, SIZE_WORD, 32'h00000044, 32'h00000000, 0, 32'hdea51234);
  add_entry("byte_load_b3", 1'b0, SIZE_BYTE, 32'h00000047, 32'h00000000, 0, 32'h000000de);
  // store miss with a load right behind it
  add_entry("store_miss_b1", 1'b1, SIZE_BYTE, 32'h00000049, 32'h00000077, 0, 32'h00000000);
  add_entry("load_miss_fill", 1'b0, SIZE_WORD, 32'h00000048, 32'h00000000, 0, 32'h00007700);
  // uncached path
  add_entry("uc_read_alias", 1'b0, SIZE_WORD, 32'h80000044, 32'h00000000, 0, 32'hdea51234);
  add_entry("uc_write", 1'b1, SIZE_WORD, 32'h80000080, 32'hcafef00d, 0, 32'h00000000);
  add_entry("uc_read_back", 1'b0, SIZE_WORD, 32'h80000080, 32'h00000000, 0, 32'hcafef00d);
  add_entry("cached_alias", 1'b0, SIZE_WORD, 32'h00000080, 32'h00000000, 0, 32'hcafef00d);
  // back-pressure on hits
  add_entry("stall_word", 1'b0, SIZE_WORD, 32'h00000080, 32'h00000000, 4, 32'hcafef00d);
  add_entry("stall_byte", 1'b0, SIZE_BYTE, 32'h00000081, 32'h00000000, 2, 32'h000000f0);
  // eviction through a tag that shares the memory word
  add_entry("evict_store", 1'b1, SIZE_WORD, 32'h00001044, 32'h0badf00d, 0, 32'h00000000);
  add_entry("evict_load_old", 1'b0, SIZE_WORD, 32'h00000044, 32'h00000000, 0, 32'h0badf00d);
  add_entry("evict_half_new", 1'b0, SIZE_HALF, 32'h00001046, 32'h00000000, 0, 32'h00000bad);
endtask

`endif

/* verif/lsu_tb.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int          HIT_LATENCY = 3;
  localparam int          N_RANDOM    = 200;
  localparam logic [31:0] SEED        = 32'h26ea7802;

  typedef struct {
    string     name;
    logic      write;
    lsu_size_e size;
    lsu_word_t addr;
    lsu_word_t wdata;
    int        stall;
    lsu_word_t expected;
  } tb_entry_t;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      req_valid;
  logic      req_write;
  lsu_size_e req_size;
  lsu_addr_u req_addr;
  lsu_word_t req_wdata;
  logic      stall;
  logic      busy;
  lsu_word_t rdata;
  logic      rvalid;

  tb_entry_t   table_q[$];
  lsu_word_t   ref_mem [`LSU_MEM_WORDS];
  lsu_tag_t    tag_model [`LSU_LINES];
  logic [31:0] rng;
  int          cycles = 0;
  int          timeout_limit = 1000;
  logic        prev_idle;

  // the one load in flight, read by the result monitor
  logic      load_pending;
  string     pend_name;
  lsu_word_t pend_expected;
  int        pend_issue_cycle;
  logic      pend_check_lat;

  lsu_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid_i(req_valid),
    .req_write_i(req_write),
    .req_size_i (req_size),
    .req_addr_i (req_addr),
    .req_wdata_i(req_wdata),
    .stall_i    (stall),
    .busy_o     (busy),
    .rdata_o    (rdata),
    .rvalid_o   (rvalid)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input lsu_word_t expected, input lsu_word_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_hit_latency(input string name, input int expected, input int actual);
    if (expected != actual) begin
      abort_run($sformatf("mismatch %s: expected %0d cycles, actual %0d cycles",
                          name, expected, actual));
    end
  endtask

  task automatic add_entry(input string name, input logic write, input lsu_size_e size,
                           input lsu_word_t addr, input lsu_word_t wdata, input int stall_cyc,
                           input lsu_word_t expected);
    tb_entry_t e;
    e.name     = name;
    e.write    = write;
    e.size     = size;
    e.addr     = addr;
    e.wdata    = wdata;
    e.stall    = stall_cyc;
    e.expected = expected;
    table_q.push_back(e);
  endtask

  `include "lsu_tb_table.svh"

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory seen as zero at reset, changed by every store
  function automatic lsu_word_t model_read(input lsu_word_t addr, input lsu_size_e size);
    lsu_word_t word;
    int        lsb;
    word = ref_mem[addr[`LSU_MEM_AW+1:2]];
    lsb  = 8 * addr[1:0];
    case (size)
      SIZE_BYTE: return {24'h0, word[lsb +: 8]};
      SIZE_HALF: return {16'h0, word[lsb +: 16]};
      default:   return word;
    endcase
  endfunction

  task automatic model_write(input lsu_word_t addr, input lsu_size_e size, input lsu_word_t wdata);
    int w;
    int lsb;
    w   = addr[`LSU_MEM_AW+1:2];
    lsb = 8 * addr[1:0];
    case (size)
      SIZE_BYTE: ref_mem[w][lsb +: 8] = wdata[7:0];
      SIZE_HALF: ref_mem[w][lsb +: 16] = wdata[15:0];
      default:   ref_mem[w] = wdata;
    endcase
  endtask

  // no extra edge here, so a request can follow a store back to back
  task automatic wait_ready();
    while (busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_entry(input tb_entry_t e);
    lsu_addr_u a;
    logic      hit;
    a.raw = e.addr;
    hit   = tag_model[a.fields.index].valid && (tag_model[a.fields.index].tag == a.fields.tag);
    wait_ready();
    req_valid  = 1'b1;
    req_write  = e.write;
    req_size   = e.size;
    req_addr   = a;
    req_wdata  = e.wdata;
    if (!e.write) begin
      pend_name        = e.name;
      pend_expected    = e.expected;
      pend_issue_cycle = cycles;
      // exact hit timing only holds on an empty pipeline
      pend_check_lat   = prev_idle && !a.fields.uncached && hit && (e.stall == 0);
      load_pending     = 1'b1;
    end else begin
      model_write(e.addr, e.size, e.wdata);
    end
    // write-allocate, so stores fill the line too
    if (!a.fields.uncached) begin
      tag_model[a.fields.index].valid = 1'b1;
      tag_model[a.fields.index].tag   = a.fields.tag;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    if (e.stall > 0) begin
      stall = 1'b1;
      repeat (e.stall) begin
        @(posedge clk);
        #1;
        if (rvalid) begin
          abort_run($sformatf("%s: rvalid_o went high while stall_i was held", e.name));
        end
      end
      stall = 1'b0;
    end
    if (!e.write) begin
      while (load_pending) begin
        @(posedge clk);
        #1;
      end
    end
    prev_idle = !e.write;
  endtask

  task automatic make_random_entry(input int n, output tb_entry_t e);
    logic [31:0] r;
    lsu_addr_u   a;
    rng = lcg_next(rng);
    r   = rng;
    e.name  = $sformatf("random_%0d", n);
    e.write = (r[31:29] < 3'd3);
    case (r[28:27])
      2'd0:    e.size = SIZE_BYTE;
      2'd1:    e.size = SIZE_HALF;
      default: e.size = SIZE_WORD;
    endcase
    // small range keeps hits, bit 12 aliases the same memory word
    a.raw      = 32'h0;
    a.raw[7:0] = r[24:17];
    a.raw[12]  = r[26] & r[25];
    if (e.size == SIZE_HALF) begin
      a.raw[0] = 1'b0;
    end else if (e.size == SIZE_WORD) begin
      a.raw[1:0] = 2'b00;
    end
    // uncached reads only, an uncached write could leave a cached line stale
    if (!e.write && (r[16:15] == 2'b11)) begin
      a.raw[31] = 1'b1;
    end
    e.addr     = a.raw;
    rng        = lcg_next(rng);
    e.wdata    = rng;
    e.stall    = 0;
    e.expected = e.write ? 32'h0 : model_read(e.addr, e.size);
  endtask

  // result monitor, outputs settled at the falling edge
  always @(negedge clk) begin
    if (rst_n && rvalid) begin
      if (!load_pending) begin
        abort_run("rvalid_o pulsed with no load outstanding");
      end else begin
        if (pend_check_lat) begin
          check_hit_latency(pend_name, HIT_LATENCY, cycles - pend_issue_cycle);
        end
        check_data(pend_name, pend_expected, rdata);
        load_pending = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_limit) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", timeout_limit));
    end
  end

  initial begin
    tb_entry_t e;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_write    = 1'b0;
    req_size     = SIZE_WORD;
    req_addr     = '0;
    req_wdata    = '0;
    stall        = 1'b0;
    load_pending = 1'b0;
    prev_idle    = 1'b1;
    for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    for (int i = 0; i < `LSU_LINES; i++) begin
      tag_model[i] = '0;
    end
    build_table();
    timeout_limit = 40 + (table_q.size() + N_RANDOM) * (2 * `LSU_MEM_LAT + 10);
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // valid sweep holds off requests right after reset
    if (!busy) begin
      abort_run("busy_o was low while the cache valid bits were being cleared");
    end
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    rng = SEED;
    for (int n = 0; n < N_RANDOM; n++) begin
      make_random_entry(n, e);
      run_entry(e);
    end
    wait_ready();
    if (load_pending) begin
      abort_run("last load never returned a result");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* logic/lsu_top.sv */
`default_nettype none

module lsu_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req_valid_i,
  input  wire                     req_write_i,
  input  wire lsu_pkg::lsu_size_e req_size_i,
  input  wire lsu_pkg::lsu_addr_u req_addr_i,
  input  wire lsu_pkg::lsu_word_t req_wdata_i,
  input  wire                     stall_i,
  output logic                    busy_o,
  output lsu_pkg::lsu_word_t      rdata_o,
  output logic                    rvalid_o
);
  import lsu_pkg::*;

  lsu_addr_u    rd_addr;
  cache_rd_t    rd;
  cache_snoop_t cache_wr;
  cache_snoop_t snoop;
  mem_req_t     mem_req;
  mem_resp_t    mem_resp;
  logic         pipe_busy;
  logic         init_busy;

  lsu_pipe u_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid_i(req_valid_i),
    .req_write_i(req_write_i),
    .req_size_i (req_size_i),
    .req_addr_i (req_addr_i),
    .req_wdata_i(req_wdata_i),
    .stall_i    (stall_i),
    .rd_addr_o  (rd_addr),
    .rd_i       (rd),
    .snoop_i    (snoop),
    .mem_req_o  (mem_req),
    .mem_resp_i (mem_resp),
    .busy_o     (pipe_busy),
    .rdata_o    (rdata_o),
    .rvalid_o   (rvalid_o)
  );

  dcache_store u_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_addr_i  (rd_addr),
    .rd_o       (rd),
    .wr_i       (cache_wr),
    .snoop_o    (snoop),
    .init_busy_o(init_busy)
  );

  mem_manager u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (mem_req),
    .resp_o    (mem_resp),
    .cache_wr_o(cache_wr)
  );

  // valid sweep after reset also holds off requests
  assign busy_o = pipe_busy | init_busy;

endmodule

`default_nettype wire

/* logic/mem_manager.sv */
`default_nettype none

`include "lsu_params.svh"

module mem_manager (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire lsu_pkg::mem_req_t  req_i,
  output lsu_pkg::mem_resp_t      resp_o,
  output lsu_pkg::cache_snoop_t   cache_wr_o
);
  import lsu_pkg::*;

  localparam int CNT_W = $clog2(`LSU_MEM_LAT + 1);

  // backing memory starts out as zeros
  lsu_word_t mem [`LSU_MEM_WORDS] = '{default: '0};

  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             op_refill_q, op_write_q, op_ucrd_q;
  lsu_addr_u        addr_q;
  lsu_word_t        wdata_q;
  logic [3:0]       strobe_q;

  logic                   start, done;
  logic [`LSU_MEM_AW-1:0] waddr;
  lsu_word_t              rword;

  assign start = !busy_q && (req_i.refill || req_i.write || req_i.uc_read);
  assign done  = busy_q && (cnt_q == '0);
  assign waddr = addr_q.raw[`LSU_MEM_AW+1:2];
  assign rword = mem[waddr];

  // latency counter, counts down to the done cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q      <= 1'b0;
      cnt_q       <= '0;
      op_refill_q <= 1'b0;
      op_write_q  <= 1'b0;
      op_ucrd_q   <= 1'b0;
    end else if (start) begin
      busy_q      <= 1'b1;
      cnt_q       <= CNT_W'(`LSU_MEM_LAT - 1);
      op_refill_q <= req_i.refill;
      op_write_q  <= req_i.write;
      op_ucrd_q   <= req_i.uc_read;
    end else if (done) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q   <= req_i.addr;
      wdata_q  <= req_i.wdata;
      strobe_q <= req_i.strobe;
    end
  end

  // write-through lands in memory on the done edge
  always_ff @(posedge clk) begin
    if (done && op_write_q) begin
      for (int b = 0; b < 4; b++) begin
        if (strobe_q[b]) begin
          mem[waddr][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    cache_wr_o           = '0;
    cache_wr_o.index     = addr_q.fields.index;
    cache_wr_o.tag.valid = 1'b1;
    cache_wr_o.tag.tag   = addr_q.fields.tag;
    cache_wr_o.data      = op_refill_q ? rword : wdata_q;
    if (done && op_refill_q) begin
      cache_wr_o.tag_we  = 1'b1;
      cache_wr_o.data_we = 4'hf;
    end else if (done && op_write_q && !addr_q.fields.uncached) begin
      // cached stores only reach here after a hit, so the line is present
      cache_wr_o.data_we = strobe_q;
    end
  end

  assign resp_o.done  = done;
  assign resp_o.rdata = rword;

  // done only while the pipe still holds the strobe of the running operation
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
    resp_o.done |-> (op_refill_q && req_i.refill) || (op_write_q && req_i.write) ||
                    (op_ucrd_q && req_i.uc_read));

endmodule

`default_nettype wire

/* logic/dcache_store.sv */
`default_nettype none

`include "lsu_params.svh"

module dcache_store (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire lsu_pkg::lsu_addr_u    rd_addr_i,
  output lsu_pkg::cache_rd_t         rd_o,
  input  wire lsu_pkg::cache_snoop_t wr_i,
  output lsu_pkg::cache_snoop_t      snoop_o,
  output logic                       init_busy_o
);
  import lsu_pkg::*;

  lsu_tag_t  tag_mem  [`LSU_LINES];
  lsu_word_t data_mem [`LSU_LINES];

  logic [`LSU_INDEX_W-1:0] init_idx_q;
  logic                    init_busy_q;
  logic                    tag_we;
  logic [3:0]              data_we;
  cache_rd_t               rd_n;

  // writes held off until the valid sweep is over
  assign tag_we  = wr_i.tag_we & ~init_busy_q;
  assign data_we = wr_i.data_we & {4{~init_busy_q}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      init_busy_q <= 1'b1;
      init_idx_q  <= '0;
    end else if (init_busy_q) begin
      init_idx_q <= init_idx_q + 1'b1;
      if (&init_idx_q) begin
        init_busy_q <= 1'b0;
      end
    end
  end

  assign init_busy_o = init_busy_q;

  always_ff @(posedge clk) begin
    if (init_busy_q) begin
      tag_mem[init_idx_q] <= '0;
    end else if (tag_we) begin
      tag_mem[wr_i.index] <= wr_i.tag;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (data_we[b]) begin
        data_mem[wr_i.index][8*b +: 8] <= wr_i.data[8*b +: 8];
      end
    end
  end

  always_comb begin
    rd_n.tag  = tag_mem[rd_addr_i.fields.index];
    rd_n.data = data_mem[rd_addr_i.fields.index];
  end

  always_ff @(posedge clk) begin
    rd_o <= rd_n;
  end

  // broadcast exactly what went into the arrays
  always_comb begin
    snoop_o         = wr_i;
    snoop_o.tag_we  = tag_we;
    snoop_o.data_we = data_we;
  end

  a_no_write_in_init: assert property (@(posedge clk) disable iff (!rst_n)
    init_busy_o |-> !(wr_i.tag_we || (|wr_i.data_we)));

endmodule

`default_nettype wire

/* logic/lsu_pipe.sv */
`default_nettype none

module lsu_pipe (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        req_valid_i,
  input  wire                        req_write_i,
  input  wire lsu_pkg::lsu_size_e    req_size_i,
  input  wire lsu_pkg::lsu_addr_u    req_addr_i,
  input  wire lsu_pkg::lsu_word_t    req_wdata_i,
  input  wire                        stall_i,
  output lsu_pkg::lsu_addr_u         rd_addr_o,
  input  wire lsu_pkg::cache_rd_t    rd_i,
  input  wire lsu_pkg::cache_snoop_t snoop_i,
  output lsu_pkg::mem_req_t          mem_req_o,
  input  wire lsu_pkg::mem_resp_t    mem_resp_i,
  output logic                       busy_o,
  output lsu_pkg::lsu_word_t         rdata_o,
  output logic                       rvalid_o
);
  import lsu_pkg::*;

  // M2 states, one-hot
  localparam logic [4:0] S_NORMAL    = 5'b00001;
  localparam logic [4:0] S_REFILL    = 5'b00010;
  localparam logic [4:0] S_WRITE     = 5'b00100;
  localparam logic [4:0] S_UC_READ   = 5'b01000;
  localparam logic [4:0] S_WR_REFILL = 5'b10000;

  logic      m1_valid_q, m1_write_q, m1_first_q;
  lsu_size_e m1_size_q;
  lsu_addr_u m1_addr_q;
  lsu_word_t m1_wdata_q;
  cache_rd_t m1_line_q, m1_line;

  logic      m2_valid_q, m2_write_q, m2_done_q;
  lsu_size_e m2_size_q;
  lsu_addr_u m2_addr_q;
  lsu_word_t m2_wdata_q;
  cache_rd_t m2_line_q, m2_line;

  logic [4:0] state_q, state_n;
  logic       m2_hit, m2_uc, m2_complete, m2_adv;
  logic [3:0] m2_strobe;
  lsu_word_t  m2_lane, m2_fmt;

  logic      wb_valid_q;
  lsu_word_t wb_data_q;

  // overlay an array write onto a private copy of the line
  function automatic cache_rd_t apply_snoop(cache_rd_t cur, lsu_addr_u addr, cache_snoop_t sn);
    cache_rd_t res;
    res = cur;
    if (sn.index == addr.fields.index) begin
      if (sn.tag_we) begin
        res.tag = sn.tag;
      end
      for (int b = 0; b < 4; b++) begin
        if (sn.data_we[b]) begin
          res.data[8*b +: 8] = sn.data[8*b +: 8];
        end
      end
    end
    return res;
  endfunction

  // EX: array read is issued straight from the request address
  assign rd_addr_o = req_addr_i;

  assign m2_hit = m2_line_q.tag.valid && (m2_line_q.tag.tag == m2_addr_q.fields.tag);
  assign m2_uc = m2_addr_q.fields.uncached;
  // a store retires once its write-through is done, a cached load on a hit
  assign m2_complete = m2_valid_q && (state_q == S_NORMAL) &&
                       (m2_done_q || (!m2_write_q && !m2_uc && m2_hit));
  assign busy_o = m2_valid_q && !m2_complete;
  assign m2_adv = !stall_i && !busy_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m1_valid_q <= 1'b0;
      m1_first_q <= 1'b0;
      m2_valid_q <= 1'b0;
    end else begin
      m1_first_q <= m2_adv && req_valid_i;
      if (m2_adv) begin
        m1_valid_q <= req_valid_i;
        m2_valid_q <= m1_valid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (m2_adv) begin
      m1_write_q <= req_write_i;
      m1_size_q  <= req_size_i;
      m1_addr_q  <= req_addr_i;
      m1_wdata_q <= req_wdata_i;
      m2_write_q <= m1_write_q;
      m2_size_q  <= m1_size_q;
      m2_addr_q  <= m1_addr_q;
      m2_wdata_q <= m1_wdata_q;
    end
  end

  // fresh array data only in the first M1 cycle, the held copy after that
  always_comb begin
    m1_line = apply_snoop(m1_first_q ? rd_i : m1_line_q, m1_addr_q, snoop_i);
  end

  always_comb begin
    m2_line = apply_snoop(m2_line_q, m2_addr_q, snoop_i);
    if ((state_q == S_UC_READ) && mem_resp_i.done) begin
      m2_line.data = mem_resp_i.rdata;
    end
  end

  // copies keep tracking the snoop bus even while stalled
  always_ff @(posedge clk) begin
    m1_line_q <= m1_line;
    m2_line_q <= m2_adv ? m1_line : m2_line;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= S_NORMAL;
      m2_done_q <= 1'b0;
    end else begin
      state_q <= state_n;
      if (m2_adv) begin
        m2_done_q <= 1'b0;
      end else if (mem_resp_i.done && ((state_q == S_WRITE) || (state_q == S_UC_READ))) begin
        m2_done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    state_n = state_q;
    case (state_q)
      S_NORMAL: begin
        if (m2_valid_q && !m2_done_q) begin
          if (m2_write_q) begin
            // write-allocate: a cached store miss refills first
            state_n = (m2_uc || m2_hit) ? S_WRITE : S_WR_REFILL;
          end else if (m2_uc) begin
            state_n = S_UC_READ;
          end else if (!m2_hit) begin
            state_n = S_REFILL;
          end
        end
      end
      S_REFILL, S_WRITE, S_UC_READ: begin
        if (mem_resp_i.done) begin
          state_n = S_NORMAL;
        end
      end
      S_WR_REFILL: begin
        if (mem_resp_i.done) begin
          state_n = S_WRITE;
        end
      end
      default: begin
        state_n = S_NORMAL;
      end
    endcase
  end

  always_comb begin
    case (m2_size_q)
      SIZE_BYTE: m2_strobe = 4'b0001 << m2_addr_q.fields.offset;
      SIZE_HALF: m2_strobe = 4'b0011 << m2_addr_q.fields.offset;
      default:   m2_strobe = 4'b1111;
    endcase
  end

  always_comb begin
    mem_req_o.refill  = (state_q == S_REFILL) || (state_q == S_WR_REFILL);
    mem_req_o.write   = (state_q == S_WRITE);
    mem_req_o.uc_read = (state_q == S_UC_READ);
    mem_req_o.addr    = m2_addr_q;
    mem_req_o.wdata   = m2_wdata_q << {m2_addr_q.fields.offset, 3'b000};
    mem_req_o.strobe  = m2_strobe;
  end

  // load formatting, zero extended
  always_comb begin
    m2_lane = m2_line_q.data >> {m2_addr_q.fields.offset, 3'b000};
    case (m2_size_q)
      SIZE_BYTE: m2_fmt = {24'h0, m2_lane[7:0]};
      SIZE_HALF: m2_fmt = {16'h0, m2_lane[15:0]};
      default:   m2_fmt = m2_lane;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= m2_adv && m2_valid_q && !m2_write_q;
    end
  end

  always_ff @(posedge clk) begin
    if (m2_adv) begin
      wb_data_q <= m2_fmt;
    end
  end

  assign rdata_o  = wb_data_q;
  assign rvalid_o = wb_valid_q;

  a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state_q));

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({mem_req_o.refill, mem_req_o.write, mem_req_o.uc_read}));

endmodule

`default_nettype wire

/* logic/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  typedef logic [31:0] lsu_word_t;

  typedef struct packed {
    logic                    uncached;
    logic [`LSU_TAG_W-1:0]   tag;
    logic [`LSU_INDEX_W-1:0] index;
    logic [1:0]              offset;
  } lsu_addr_fields_t;

  // same address seen as a plain word or split for the cache
  typedef union packed {
    lsu_word_t        raw;
    lsu_addr_fields_t fields;
  } lsu_addr_u;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  typedef struct packed {
    logic                  valid;
    logic [`LSU_TAG_W-1:0] tag;
  } lsu_tag_t;

  // strobes are levels, held until done
  typedef struct packed {
    logic      refill;
    logic      write;
    logic      uc_read;
    lsu_addr_u addr;
    lsu_word_t wdata;
    logic [3:0] strobe;
  } mem_req_t;

  typedef struct packed {
    logic      done;
    lsu_word_t rdata;
  } mem_resp_t;

  typedef struct packed {
    lsu_tag_t  tag;
    lsu_word_t data;
  } cache_rd_t;

  typedef struct packed {
    logic                    tag_we;
    logic [3:0]              data_we;
    logic [`LSU_INDEX_W-1:0] index;
    lsu_tag_t                tag;
    lsu_word_t               data;
  } cache_snoop_t;

endpackage

`default_nettype wire

/* logic/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// cache geometry, one word per line
`define LSU_INDEX_W 4
`define LSU_LINES (1 << `LSU_INDEX_W)

// tag is what is left after the uncached bit, index and byte offset
`define LSU_TAG_W (32 - 1 - `LSU_INDEX_W - 2)

// backing memory, word addressed
`define LSU_MEM_AW 8
`define LSU_MEM_WORDS (1 << `LSU_MEM_AW)

// cycles from start to done for every memory operation
`define LSU_MEM_LAT 4

`endif
